//--- Makefile
# Verilator build and run of the pipeline testbench

VERILATOR  ?= verilator
TOP        ?= pipe_core_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Test completed successfully" $(LOG); then \
		echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+include
src/pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/writeback_stage.sv
src/hazard_control.sv
src/pipe_core_top.sv
verif/pipe_core_sva.sv
verif/pipe_core_tb.sv

//--- include/pipe_macros.svh
// Data widths, instruction field positions, data RAM depth and multiply length
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

`define PIPE_XLEN        32  // Data path width
`define PIPE_REG_AW      5   // Register address width
`define PIPE_PC_W        10  // Instruction word address width

`define PIPE_OP_HI       31
`define PIPE_OP_LO       28
`define PIPE_RD_HI       27
`define PIPE_RD_LO       23
`define PIPE_RS1_HI      22
`define PIPE_RS1_LO      18
`define PIPE_RS2_HI      17
`define PIPE_RS2_LO      13
`define PIPE_IMM_HI      12  // Signed immediate down to bit 0

`define PIPE_DMEM_WORDS  16
`define PIPE_MUL_CYCLES  4   // Execute occupancy of one multiply

`endif

//--- src/decode_stage.sv
// Decode stage: field split, register file, forwarding muxes and decode/execute register
`timescale 1ns/1ps
`default_nettype none
`include "pipe_macros.svh"

module decode_stage (
    input  wire                      clk_i,
    input  wire                      rst_i,
    input  wire [31:0]               if_instr_i,
    input  wire [`PIPE_PC_W-1:0]     if_pc_i,
    input  wire                      if_valid_i,
    input  wire                      front_stall_i,
    input  wire                      front_flush_i,
    input  wire                      exe_stall_i,
    input  pipe_pkg::fwd_sel_e       fwd_sel_a_i,
    input  pipe_pkg::fwd_sel_e       fwd_sel_b_i,
    input  wire [`PIPE_XLEN-1:0]     ex_result_i,
    input  wire [`PIPE_XLEN-1:0]     wb_data_i,
    input  wire                      wb_we_i,
    input  wire [`PIPE_REG_AW-1:0]   wb_rd_i,
    output logic [`PIPE_REG_AW-1:0]  rs1_o,
    output logic [`PIPE_REG_AW-1:0]  rs2_o,
    output pipe_pkg::opcode_e        id_op_o,
    output logic [`PIPE_REG_AW-1:0]  id_rd_o,
    output logic [`PIPE_XLEN-1:0]    id_a_o,
    output logic [`PIPE_XLEN-1:0]    id_b_o,
    output logic [`PIPE_XLEN-1:0]    id_imm_o,
    output logic [`PIPE_PC_W-1:0]    id_pc_o,
    output logic                     id_valid_o
);

    localparam int NREGS = 1 << `PIPE_REG_AW;

    logic [`PIPE_XLEN-1:0] regs [NREGS];
    logic [`PIPE_XLEN-1:0] rf_a;
    logic [`PIPE_XLEN-1:0] rf_b;
    logic [`PIPE_XLEN-1:0] imm;

    function automatic logic [`PIPE_XLEN-1:0] fwd_mux(input pipe_pkg::fwd_sel_e sel,
                                                      input logic [`PIPE_XLEN-1:0] rf_val,
                                                      input logic [`PIPE_XLEN-1:0] exe_val,
                                                      input logic [`PIPE_XLEN-1:0] wb_val);
        case (sel)
            pipe_pkg::FWD_EXE: fwd_mux = exe_val;
            pipe_pkg::FWD_WB:  fwd_mux = wb_val;
            default:           fwd_mux = rf_val;
        endcase
    endfunction

    // An empty slot asks for nothing
    assign rs1_o = if_valid_i ? if_instr_i[`PIPE_RS1_HI:`PIPE_RS1_LO] : '0;
    assign rs2_o = if_valid_i ? if_instr_i[`PIPE_RS2_HI:`PIPE_RS2_LO] : '0;

    assign rf_a = (rs1_o == '0) ? '0 : regs[rs1_o];
    assign rf_b = (rs2_o == '0) ? '0 : regs[rs2_o];
    assign imm  = {{(`PIPE_XLEN - `PIPE_IMM_HI - 1){if_instr_i[`PIPE_IMM_HI]}},
                   if_instr_i[`PIPE_IMM_HI:0]};

    // Written at the edge that ends writeback
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_valid_o <= 1'b0;
        end else if (!exe_stall_i) begin
            id_valid_o <= if_valid_i && !front_stall_i && !front_flush_i;  // Bubble on stall
        end
    end

    always_ff @(posedge clk_i) begin
        if (!exe_stall_i) begin
            id_op_o  <= pipe_pkg::opcode_e'(if_instr_i[`PIPE_OP_HI:`PIPE_OP_LO]);
            id_rd_o  <= if_instr_i[`PIPE_RD_HI:`PIPE_RD_LO];
            id_a_o   <= fwd_mux(fwd_sel_a_i, rf_a, ex_result_i, wb_data_i);
            id_b_o   <= fwd_mux(fwd_sel_b_i, rf_b, ex_result_i, wb_data_i);
            id_imm_o <= imm;
            id_pc_o  <= if_pc_i;
        end
    end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
// Execute stage: ALU, multi-cycle multiply, branch resolution and execute/writeback register
`timescale 1ns/1ps
`default_nettype none
`include "pipe_macros.svh"

module execute_stage (
    input  wire                      clk_i,
    input  wire                      rst_i,
    input  pipe_pkg::opcode_e        id_op_i,
    input  wire [`PIPE_REG_AW-1:0]   id_rd_i,
    input  wire [`PIPE_XLEN-1:0]     id_a_i,
    input  wire [`PIPE_XLEN-1:0]     id_b_i,
    input  wire [`PIPE_XLEN-1:0]     id_imm_i,
    input  wire [`PIPE_PC_W-1:0]     id_pc_i,
    input  wire                      id_valid_i,
    input  wire                      exe_stall_i,
    output logic [`PIPE_REG_AW-1:0]  ex_rd_o,
    output logic                     ex_writes_o,
    output logic                     ex_fwd_invalid_o,
    output logic                     ex_ready_o,
    output logic [`PIPE_XLEN-1:0]    ex_result_o,
    output logic                     ex_mispredict_o,
    output logic [`PIPE_PC_W-1:0]    redirect_pc_o,
    output pipe_pkg::opcode_e        ex_wb_op_o,
    output logic [`PIPE_REG_AW-1:0]  ex_wb_rd_o,
    output logic [`PIPE_XLEN-1:0]    ex_wb_res_o,
    output logic [`PIPE_XLEN-1:0]    ex_wb_sdata_o,
    output logic                     ex_wb_valid_o
);

    localparam int CW = $clog2(`PIPE_MUL_CYCLES);

    logic [CW-1:0]           cnt_q;     // Multiply cycles already spent
    logic [`PIPE_XLEN-1:0]   mul_a_q;
    logic [`PIPE_XLEN-1:0]   mul_b_q;
    logic [`PIPE_REG_AW-1:0] mul_rd_q;
    logic                    busy;
    logic                    cur_valid;
    pipe_pkg::opcode_e       cur_op;
    logic [`PIPE_XLEN-1:0]   product;
    logic                    taken;

    // A running multiply owns the stage, decode keeps feeding bubbles meanwhile
    assign busy      = (cnt_q != '0);
    assign cur_op    = busy ? pipe_pkg::OP_MUL : id_op_i;
    assign cur_valid = busy || id_valid_i;
    assign ex_rd_o   = busy ? mul_rd_q : id_rd_i;
    assign product   = busy ? (mul_a_q * mul_b_q) : (id_a_i * id_b_i);  // Low word kept

    assign ex_ready_o = !(cur_valid && (cur_op == pipe_pkg::OP_MUL) &&
                          (cnt_q != CW'(`PIPE_MUL_CYCLES - 1)));
    assign ex_fwd_invalid_o = cur_valid && (cur_op == pipe_pkg::OP_LW);

    always_comb begin
        ex_result_o = id_a_i + id_imm_i;  // Address for loads and stores
        ex_writes_o = cur_valid;
        case (cur_op)
            pipe_pkg::OP_ADD:  ex_result_o = id_a_i + id_b_i;
            pipe_pkg::OP_SUB:  ex_result_o = id_a_i - id_b_i;
            pipe_pkg::OP_AND:  ex_result_o = id_a_i & id_b_i;
            pipe_pkg::OP_OR:   ex_result_o = id_a_i | id_b_i;
            pipe_pkg::OP_XOR:  ex_result_o = id_a_i ^ id_b_i;
            pipe_pkg::OP_ADDI: ex_result_o = id_a_i + id_imm_i;
            pipe_pkg::OP_LW:   ex_result_o = id_a_i + id_imm_i;
            pipe_pkg::OP_MUL:  ex_result_o = product;
            default:           ex_writes_o = 1'b0;  // SW, branches, NOP
        endcase
    end

    // Not-taken prediction, so every taken branch redirects
    assign taken = ((cur_op == pipe_pkg::OP_BEQ) && (id_a_i == id_b_i)) ||
                   ((cur_op == pipe_pkg::OP_BNE) && (id_a_i != id_b_i));
    assign ex_mispredict_o = cur_valid && taken && !exe_stall_i;
    assign redirect_pc_o   = id_pc_i + `PIPE_PC_W'(1) + id_imm_i[`PIPE_PC_W-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q         <= '0;
            ex_wb_valid_o <= 1'b0;
        end else if (exe_stall_i) begin
            ex_wb_valid_o <= 1'b0;  // Held here, bubble downstream
        end else begin
            ex_wb_valid_o <= ex_ready_o && (ex_writes_o ||
                             (cur_valid && (cur_op == pipe_pkg::OP_SW)));
            if (cur_valid && (cur_op == pipe_pkg::OP_MUL)) begin
                cnt_q <= ex_ready_o ? '0 : cnt_q + CW'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!exe_stall_i) begin
            ex_wb_op_o    <= cur_op;
            ex_wb_rd_o    <= ex_rd_o;
            ex_wb_res_o   <= ex_result_o;
            ex_wb_sdata_o <= id_b_i;
            if (!busy) begin
                mul_a_q  <= id_a_i;  // Operands for a starting multiply
                mul_b_q  <= id_b_i;
                mul_rd_q <= id_rd_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
// Fetch stage: program counter, instruction request and fetch register
`timescale 1ns/1ps
`default_nettype none
`include "pipe_macros.svh"

module fetch_stage (
    input  wire                    clk_i,
    input  wire                    rst_i,
    input  wire                    front_stall_i,
    input  wire                    front_flush_i,
    input  wire                    redirect_i,
    input  wire [`PIPE_PC_W-1:0]   redirect_pc_i,
    output logic [`PIPE_PC_W-1:0]  imem_addr_o,
    input  wire [31:0]             imem_data_i,
    input  wire                    imem_ready_i,
    output logic                   fetch_ready_o,
    output logic [31:0]            if_instr_o,
    output logic [`PIPE_PC_W-1:0]  if_pc_o,
    output logic                   if_valid_o
);

    logic [`PIPE_PC_W-1:0] pc_q;  // Address of the outstanding request
    logic                  take;  // Arriving word goes into the fetch register

    assign fetch_ready_o = imem_ready_i;
    assign take = imem_ready_i && !front_stall_i && !front_flush_i;

    // Next request, issued this cycle
    always_comb begin
        if (redirect_i) begin
            imem_addr_o = redirect_pc_i;
        end else if (take) begin
            imem_addr_o = pc_q + `PIPE_PC_W'(1);
        end else begin
            imem_addr_o = pc_q;  // Repeat the request
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q       <= '0;
            if_valid_o <= 1'b0;
        end else begin
            pc_q <= imem_addr_o;
            if (front_flush_i) begin
                if_valid_o <= 1'b0;  // Drop the word in flight
            end else if (!front_stall_i) begin
                if_valid_o <= imem_ready_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            if_instr_o <= imem_data_i;
            if_pc_o    <= pc_q;
        end
    end

endmodule

`default_nettype wire

//--- src/hazard_control.sv
// Hazard unit: forwarding select, load-use and multiply stalls, flush generation
`timescale 1ns/1ps
`default_nettype none
`include "pipe_macros.svh"

module hazard_control (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     fetch_ready_i,
    input  wire                     ex_mispredict_i,
    input  wire [`PIPE_REG_AW-1:0]  rs1_i,
    input  wire [`PIPE_REG_AW-1:0]  rs2_i,
    input  wire [`PIPE_REG_AW-1:0]  ex_rd_i,
    input  wire                     ex_writes_i,
    input  wire                     ex_fwd_invalid_i,
    input  wire                     ex_ready_i,
    input  wire [`PIPE_REG_AW-1:0]  wb_rd_i,
    input  wire                     wb_we_i,
    output pipe_pkg::fwd_sel_e      fwd_sel_a_o,
    output pipe_pkg::fwd_sel_e      fwd_sel_b_o,
    output logic                    front_stall_o,
    output logic                    front_flush_o,
    output logic                    exe_stall_o
);

    logic start_q;       // First cycle after reset
    logic stall_done_q;  // Load-use bubble already inserted
    logic load_use;

    function automatic pipe_pkg::fwd_sel_e pick(input logic [`PIPE_REG_AW-1:0] rs,
                                                input logic [`PIPE_REG_AW-1:0] exe_rd,
                                                input logic exe_ok,
                                                input logic [`PIPE_REG_AW-1:0] wb_rd,
                                                input logic wb_ok);
        if ((rs != '0) && exe_ok && (rs == exe_rd)) begin
            pick = pipe_pkg::FWD_EXE;
        end else if ((rs != '0) && wb_ok && (rs == wb_rd)) begin
            pick = pipe_pkg::FWD_WB;
        end else begin
            pick = pipe_pkg::FWD_NONE;
        end
    endfunction

    always_comb begin
        fwd_sel_a_o = pick(rs1_i, ex_rd_i, ex_writes_i && !ex_fwd_invalid_i, wb_rd_i, wb_we_i);
        fwd_sel_b_o = pick(rs2_i, ex_rd_i, ex_writes_i && !ex_fwd_invalid_i, wb_rd_i, wb_we_i);
    end

    // Load result exists only in writeback
    assign load_use = ex_writes_i && ex_fwd_invalid_i && (ex_rd_i != '0) &&
                      ((rs1_i == ex_rd_i) || (rs2_i == ex_rd_i));

    assign front_stall_o = !ex_ready_i || !fetch_ready_i || (load_use && !stall_done_q);
    assign exe_stall_o   = !fetch_ready_i;
    assign front_flush_o = start_q || ex_mispredict_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_q      <= 1'b1;
            stall_done_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (!exe_stall_o) begin
                stall_done_q <= !stall_done_q && load_use;  // Counts only a taken bubble
            end
        end
    end

endmodule

`default_nettype wire

//--- src/pipe_core_top.sv
// Pipeline top: four stages and the hazard unit
`timescale 1ns/1ps
`default_nettype none
`include "pipe_macros.svh"

module pipe_core_top (
    input  wire                      clk_i,
    input  wire                      rst_i,
    output logic [`PIPE_PC_W-1:0]    imem_addr_o,
    input  wire [31:0]               imem_data_i,
    input  wire                      imem_ready_i,
    output logic                     retire_valid_o,
    output logic [`PIPE_REG_AW-1:0]  retire_rd_o,
    output logic [`PIPE_XLEN-1:0]    retire_data_o
);

    logic [31:0]             if_instr;
    logic [`PIPE_PC_W-1:0]   if_pc;
    logic                    if_valid;
    logic                    fetch_ready;
    logic [`PIPE_REG_AW-1:0] rs1;
    logic [`PIPE_REG_AW-1:0] rs2;
    pipe_pkg::fwd_sel_e      fwd_sel_a;
    pipe_pkg::fwd_sel_e      fwd_sel_b;
    pipe_pkg::opcode_e       id_op;
    logic [`PIPE_REG_AW-1:0] id_rd;
    logic [`PIPE_XLEN-1:0]   id_a;
    logic [`PIPE_XLEN-1:0]   id_b;
    logic [`PIPE_XLEN-1:0]   id_imm;
    logic [`PIPE_PC_W-1:0]   id_pc;
    logic                    id_valid;
    logic [`PIPE_REG_AW-1:0] ex_rd;
    logic                    ex_writes;
    logic                    ex_fwd_invalid;
    logic                    ex_ready;
    logic [`PIPE_XLEN-1:0]   ex_result;
    logic                    ex_mispredict;
    logic [`PIPE_PC_W-1:0]   redirect_pc;
    pipe_pkg::opcode_e       ex_wb_op;
    logic [`PIPE_REG_AW-1:0] ex_wb_rd;
    logic [`PIPE_XLEN-1:0]   ex_wb_res;
    logic [`PIPE_XLEN-1:0]   ex_wb_sdata;
    logic                    ex_wb_valid;
    logic [`PIPE_REG_AW-1:0] wb_rd;
    logic                    wb_we;
    logic [`PIPE_XLEN-1:0]   wb_data;
    logic                    front_stall;
    logic                    front_flush;
    logic                    exe_stall;

    fetch_stage u_fetch (
        .clk_i(clk_i), .rst_i(rst_i),
        .front_stall_i(front_stall), .front_flush_i(front_flush),
        .redirect_i(ex_mispredict), .redirect_pc_i(redirect_pc),
        .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i), .imem_ready_i(imem_ready_i),
        .fetch_ready_o(fetch_ready),
        .if_instr_o(if_instr), .if_pc_o(if_pc), .if_valid_o(if_valid)
    );

    decode_stage u_decode (
        .clk_i(clk_i), .rst_i(rst_i),
        .if_instr_i(if_instr), .if_pc_i(if_pc), .if_valid_i(if_valid),
        .front_stall_i(front_stall), .front_flush_i(front_flush), .exe_stall_i(exe_stall),
        .fwd_sel_a_i(fwd_sel_a), .fwd_sel_b_i(fwd_sel_b),
        .ex_result_i(ex_result), .wb_data_i(wb_data),
        .wb_we_i(wb_we), .wb_rd_i(wb_rd),
        .rs1_o(rs1), .rs2_o(rs2),
        .id_op_o(id_op), .id_rd_o(id_rd), .id_a_o(id_a), .id_b_o(id_b),
        .id_imm_o(id_imm), .id_pc_o(id_pc), .id_valid_o(id_valid)
    );

    execute_stage u_execute (
        .clk_i(clk_i), .rst_i(rst_i),
        .id_op_i(id_op), .id_rd_i(id_rd), .id_a_i(id_a), .id_b_i(id_b),
        .id_imm_i(id_imm), .id_pc_i(id_pc), .id_valid_i(id_valid),
        .exe_stall_i(exe_stall),
        .ex_rd_o(ex_rd), .ex_writes_o(ex_writes), .ex_fwd_invalid_o(ex_fwd_invalid),
        .ex_ready_o(ex_ready), .ex_result_o(ex_result),
        .ex_mispredict_o(ex_mispredict), .redirect_pc_o(redirect_pc),
        .ex_wb_op_o(ex_wb_op), .ex_wb_rd_o(ex_wb_rd), .ex_wb_res_o(ex_wb_res),
        .ex_wb_sdata_o(ex_wb_sdata), .ex_wb_valid_o(ex_wb_valid)
    );

    writeback_stage u_writeback (
        .clk_i(clk_i), .rst_i(rst_i),
        .ex_wb_op_i(ex_wb_op), .ex_wb_rd_i(ex_wb_rd), .ex_wb_res_i(ex_wb_res),
        .ex_wb_sdata_i(ex_wb_sdata), .ex_wb_valid_i(ex_wb_valid),
        .wb_rd_o(wb_rd), .wb_we_o(wb_we), .wb_data_o(wb_data),
        .retire_valid_o(retire_valid_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o)
    );

    hazard_control u_hazard (
        .clk_i(clk_i), .rst_i(rst_i),
        .fetch_ready_i(fetch_ready), .ex_mispredict_i(ex_mispredict),
        .rs1_i(rs1), .rs2_i(rs2),
        .ex_rd_i(ex_rd), .ex_writes_i(ex_writes),
        .ex_fwd_invalid_i(ex_fwd_invalid), .ex_ready_i(ex_ready),
        .wb_rd_i(wb_rd), .wb_we_i(wb_we),
        .fwd_sel_a_o(fwd_sel_a), .fwd_sel_b_o(fwd_sel_b),
        .front_stall_o(front_stall), .front_flush_o(front_flush), .exe_stall_o(exe_stall)
    );

endmodule

`default_nettype wire

//--- src/pipe_pkg.sv
// Opcode and forwarding-select types of the pipeline
`default_nettype none

package pipe_pkg;

    // Codes 12 to 15 are unused and act as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_MUL  = 4'd7,
        OP_LW   = 4'd8,
        OP_SW   = 4'd9,
        OP_BEQ  = 4'd10,
        OP_BNE  = 4'd11
    } opcode_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,  // Register file value
        FWD_EXE  = 2'd1,  // Result of the execute stage
        FWD_WB   = 2'd2   // Write-back value
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- src/writeback_stage.sv
// Writeback stage: data RAM, load and store, register write-back and retire port
`timescale 1ns/1ps
`default_nettype none
`include "pipe_macros.svh"

module writeback_stage (
    input  wire                      clk_i,
    input  wire                      rst_i,
    input  pipe_pkg::opcode_e        ex_wb_op_i,
    input  wire [`PIPE_REG_AW-1:0]   ex_wb_rd_i,
    input  wire [`PIPE_XLEN-1:0]     ex_wb_res_i,
    input  wire [`PIPE_XLEN-1:0]     ex_wb_sdata_i,
    input  wire                      ex_wb_valid_i,
    output logic [`PIPE_REG_AW-1:0]  wb_rd_o,
    output logic                     wb_we_o,
    output logic [`PIPE_XLEN-1:0]    wb_data_o,
    output logic                     retire_valid_o,
    output logic [`PIPE_REG_AW-1:0]  retire_rd_o,
    output logic [`PIPE_XLEN-1:0]    retire_data_o
);

    localparam int DAW = $clog2(`PIPE_DMEM_WORDS);

    logic [`PIPE_XLEN-1:0] dmem [`PIPE_DMEM_WORDS];
    logic [DAW-1:0]        addr;

    assign addr = ex_wb_res_i[DAW-1:0];  // Low bits of the sum

    // Only register writers and stores reach this stage
    assign wb_we_o   = ex_wb_valid_i && (ex_wb_op_i != pipe_pkg::OP_SW);
    assign wb_rd_o   = ex_wb_rd_i;
    assign wb_data_o = (ex_wb_op_i == pipe_pkg::OP_LW) ? dmem[addr] : ex_wb_res_i;

    assign retire_valid_o = wb_we_o && (wb_rd_o != '0);  // x0 writes stay silent
    assign retire_rd_o    = wb_rd_o;
    assign retire_data_o  = wb_data_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `PIPE_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_wb_valid_i && (ex_wb_op_i == pipe_pkg::OP_SW)) begin
            dmem[addr] <= ex_wb_sdata_i;
        end
    end

endmodule

`default_nettype wire

//--- verif/pipe_core_sva.sv
// Assertions on the hazard unit outputs and their bind to hazard_control
`timescale 1ns/1ps
`default_nettype none

module pipe_core_sva (
    input wire                 clk_i,
    input wire                 rst_i,
    input wire                 front_flush_i,
    input wire                 exe_stall_i,
    input wire                 load_use_i,
    input wire                 stall_done_i,
    input wire                 ex_fwd_invalid_i,
    input pipe_pkg::fwd_sel_e  fwd_sel_a_i,
    input pipe_pkg::fwd_sel_e  fwd_sel_b_i
);

    flush_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> front_flush_i)
        else $error("front_flush low in the first cycle after reset");

    // A taken bubble moves the load on to writeback
    single_load_bubble: assert property (@(posedge clk_i) disable iff (rst_i)
        (load_use_i && !stall_done_i && !exe_stall_i) |=> !load_use_i)
        else $error("load-use stall lasted two cycles");

    no_exe_fwd_from_load: assert property (@(posedge clk_i) disable iff (rst_i)
        ex_fwd_invalid_i |-> ((fwd_sel_a_i != pipe_pkg::FWD_EXE) &&
                              (fwd_sel_b_i != pipe_pkg::FWD_EXE)))
        else $error("execute forwarding selected while a load is in execute");

endmodule

bind hazard_control pipe_core_sva u_sva (
    .clk_i(clk_i), .rst_i(rst_i),
    .front_flush_i(front_flush_o), .exe_stall_i(exe_stall_o),
    .load_use_i(load_use), .stall_done_i(stall_done_q),
    .ex_fwd_invalid_i(ex_fwd_invalid_i),
    .fwd_sel_a_i(fwd_sel_a_o), .fwd_sel_b_i(fwd_sel_b_o)
);

`default_nettype wire

//--- verif/pipe_core_tb.sv
// Testbench with program generator, instruction memory, ISA reference, retire checker, watchdog
`timescale 1ns/1ps
`default_nettype none
`include "pipe_macros.svh"

module pipe_core_tb;

    localparam int PROG_WORDS      = 256;
    localparam int PROG_AW         = 8;
    localparam int TAIL_NOPS       = 8;
    localparam int DRAIN_CYCLES    = 40;  // Quiet time that exposes extra retires
    localparam int WATCHDOG_CYCLES = 20 * PROG_WORDS;
    localparam int DMEM_AW         = $clog2(`PIPE_DMEM_WORDS);

    logic                    clk_i;
    logic                    rst_i;
    logic [`PIPE_PC_W-1:0]   imem_addr_o;
    logic [31:0]             imem_data_i;
    logic                    imem_ready_i;
    logic                    retire_valid_o;
    logic [`PIPE_REG_AW-1:0] retire_rd_o;
    logic [`PIPE_XLEN-1:0]   retire_data_o;

    logic [31:0]             prog [PROG_WORDS];
    logic [31:0]             rng_state;
    logic [`PIPE_REG_AW-1:0] exp_rd_q [$];    // Expected writes in program order
    logic [`PIPE_XLEN-1:0]   exp_data_q [$];
    int                      exp_total;
    int                      retired;
    int                      mismatch_count;
    int                      extra_count;
    int                      missing_count;

    pipe_core_top dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i), .imem_ready_i(imem_ready_i),
        .retire_valid_o(retire_valid_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [15:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];  // Upper half has the better bits
    endfunction

    task automatic gen_program();
        logic [15:0] r_op;
        logic [15:0] r_reg;
        logic [15:0] r_imm;
        logic [31:0] instr;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r_op  = next_rand();
            r_reg = next_rand();
            r_imm = next_rand();
            instr = '0;
            instr[`PIPE_OP_HI:`PIPE_OP_LO]   = r_op[3:0];  // Codes 12 to 15 act as NOP
            instr[`PIPE_RD_HI:`PIPE_RD_LO]   = {2'b00, r_reg[2:0]};
            instr[`PIPE_RS1_HI:`PIPE_RS1_LO] = {2'b00, r_reg[5:3]};
            instr[`PIPE_RS2_HI:`PIPE_RS2_LO] = {2'b00, r_reg[8:6]};
            if ((r_op[3:0] == pipe_pkg::OP_BEQ) || (r_op[3:0] == pipe_pkg::OP_BNE)) begin
                instr[`PIPE_IMM_HI:0] = {11'd0, r_imm[1:0]};  // Forward by 0 to 3 words
            end else begin
                instr[`PIPE_IMM_HI:0] = r_imm[12:0];
            end
            if (i >= PROG_WORDS - TAIL_NOPS) begin
                instr = '0;
            end
            prog[i[PROG_AW-1:0]] = instr;
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [`PIPE_PC_W-1:0] addr);
        if (addr < `PIPE_PC_W'(PROG_WORDS)) begin
            return prog[addr[PROG_AW-1:0]];
        end
        return '0;  // NOPs past the program
    endfunction

    // Runs the program in order and queues every register write to a nonzero rd
    function automatic int run_reference();
        logic [`PIPE_XLEN-1:0]   regs [32];
        logic [`PIPE_XLEN-1:0]   ram [`PIPE_DMEM_WORDS];
        logic [31:0]             instr;
        logic [3:0]              op;
        logic [`PIPE_REG_AW-1:0] rd;
        logic [`PIPE_XLEN-1:0]   a;
        logic [`PIPE_XLEN-1:0]   b;
        logic [`PIPE_XLEN-1:0]   imm;
        logic [`PIPE_XLEN-1:0]   res;
        logic [`PIPE_XLEN-1:0]   addr;
        logic [`PIPE_PC_W-1:0]   pc;
        logic                    writes;
        int                      count;
        regs  = '{default: '0};
        ram   = '{default: '0};
        pc    = '0;
        count = 0;
        while (pc < `PIPE_PC_W'(PROG_WORDS)) begin
            instr  = prog[pc[PROG_AW-1:0]];
            op     = instr[`PIPE_OP_HI:`PIPE_OP_LO];
            rd     = instr[`PIPE_RD_HI:`PIPE_RD_LO];
            a      = regs[instr[`PIPE_RS1_HI:`PIPE_RS1_LO]];
            b      = regs[instr[`PIPE_RS2_HI:`PIPE_RS2_LO]];
            imm    = {{(`PIPE_XLEN - `PIPE_IMM_HI - 1){instr[`PIPE_IMM_HI]}},
                      instr[`PIPE_IMM_HI:0]};
            addr   = a + imm;
            writes = 1'b1;
            res    = '0;
            pc     = pc + `PIPE_PC_W'(1);
            case (op)
                pipe_pkg::OP_ADD:  res = a + b;
                pipe_pkg::OP_SUB:  res = a - b;
                pipe_pkg::OP_AND:  res = a & b;
                pipe_pkg::OP_OR:   res = a | b;
                pipe_pkg::OP_XOR:  res = a ^ b;
                pipe_pkg::OP_ADDI: res = a + imm;
                pipe_pkg::OP_MUL:  res = a * b;  // Low word of the product
                pipe_pkg::OP_LW:   res = ram[addr[DMEM_AW-1:0]];
                pipe_pkg::OP_SW: begin
                    ram[addr[DMEM_AW-1:0]] = b;
                    writes = 1'b0;
                end
                pipe_pkg::OP_BEQ: begin
                    if (a == b) begin
                        pc = pc + imm[`PIPE_PC_W-1:0];  // Target is pc+1+imm
                    end
                    writes = 1'b0;
                end
                pipe_pkg::OP_BNE: begin
                    if (a != b) begin
                        pc = pc + imm[`PIPE_PC_W-1:0];
                    end
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes && (rd != '0)) begin
                regs[rd] = res;
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(res);
                count++;
            end
        end
        return count;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("FAILED at time %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d wrong values, %0d extra retires, %0d missing retires",
                 mismatch_count, extra_count, missing_count);
    endtask

    // One cycle of latency and ready low about one cycle in four
    always @(posedge clk_i) begin : imem_model
        logic [15:0] r;
        r = next_rand();
        imem_data_i  <= fetch_word(imem_addr_o);
        imem_ready_i <= (r[1:0] != 2'b00);
    end

    always @(posedge clk_i) begin : retire_check
        logic [`PIPE_REG_AW-1:0] rd_exp;
        logic [`PIPE_XLEN-1:0]   data_exp;
        if (!rst_i && (retire_valid_o === 1'b1)) begin
            if (exp_rd_q.size() == 0) begin
                extra_count++;
                $display("Unexpected retire at time %0t: register %0d written after the program",
                         $time, retire_rd_o);
            end else begin
                rd_exp   = exp_rd_q.pop_front();
                data_exp = exp_data_q.pop_front();
                check_value($sformatf("retire %0d register", retired), 32'(retire_rd_o),
                            32'(rd_exp));
                check_value($sformatf("retire %0d data", retired), retire_data_o, data_exp);
                retired++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout after %0d cycles: %0d expected register writes never retired",
                 WATCHDOG_CYCLES, exp_rd_q.size());
        missing_count = exp_rd_q.size();
        report_counts();
        $display("Test failed");
        $finish;
    end

    initial begin
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        imem_data_i    = '0;
        imem_ready_i   = 1'b0;
        rng_state      = 32'he356b1eb;
        retired        = 0;
        mismatch_count = 0;
        extra_count    = 0;
        missing_count  = 0;
        gen_program();
        exp_total = run_reference();
        $display("Program of %0d words, %0d register writes expected", PROG_WORDS, exp_total);
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        wait (retired >= exp_total);
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        report_counts();
        if ((mismatch_count + extra_count + missing_count) == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
